/* include/v810_defines.svh */
`ifndef V810_DEFINES_SVH
`define V810_DEFINES_SVH

// Data and address width
`define V810_XLEN 32

// General register file
`define V810_NREGS 32
`define V810_RA_W  5

`endif

/* design/v810_pkg.sv */
`include "v810_defines.svh"

package v810_pkg;

    typedef enum logic [3:0] {
        ALU_MOV = 4'b0000,
        ALU_ADD = 4'b0001,
        ALU_SUB = 4'b0010,
        ALU_SHL = 4'b0100,
        ALU_SHR = 4'b0101,
        ALU_SAR = 4'b0111,
        ALU_OR  = 4'b1100,
        ALU_AND = 4'b1101,
        ALU_XOR = 4'b1110,
        ALU_NOT = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG,
        SRC1_IMM5,
        SRC1_PC
    } alu_src1_e;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_DISP16,
        SRC2_DISP9
    } alu_src2_e;

    // Which half of a wrapped 32-bit instruction is being fetched
    typedef enum logic {
        FETCH_LO,
        FETCH_HI
    } fetch_state_e;

    typedef struct packed {
        logic carry;
        logic over;
        logic sign;
        logic zero;
    } flags_t;

    typedef struct packed {
        logic [`V810_XLEN-1:0] pc;
        logic [`V810_XLEN-1:0] imm5;
        logic [`V810_XLEN-1:0] disp9;
        logic [`V810_XLEN-1:0] disp16;
        logic [`V810_XLEN-1:0] rd1;
        logic [`V810_XLEN-1:0] rd2;
        logic [`V810_RA_W-1:0] wa;
        alu_op_e               alu_op;
        alu_src1_e             src1;
        alu_src2_e             src2;
        logic                  branch;
        logic [3:0]            cond;
        logic                  mem_read;
        logic                  mem_write;
        logic [3:0]            flag_mask;
        logic                  reg_write;
        logic                  mem_to_reg;
    } idex_t;

    typedef struct packed {
        logic [`V810_XLEN-1:0] result;
        flags_t                flags;
        logic [`V810_XLEN-1:0] st_data;
        logic [`V810_RA_W-1:0] wa;
        logic                  mem_read;
        logic                  mem_write;
        logic [3:0]            flag_mask;
        logic                  reg_write;
        logic                  mem_to_reg;
    } exmem_t;

endpackage

/* design/v810_fetch_if.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

interface v810_fetch_if;

    logic [`V810_XLEN-1:0] ifid_pc;     // IF/ID register
    logic [31:0]           ifid_ir;
    logic                  stall;       // Hold PC and IF/ID
    logic                  redirect;    // Taken branch
    logic [`V810_XLEN-1:0] redirect_pc;

    modport fetch (
        output ifid_pc, ifid_ir,
        input  stall, redirect, redirect_pc
    );

    modport decode (
        input  ifid_pc, ifid_ir,
        output stall
    );

    modport execute (
        output redirect, redirect_pc
    );

endinterface

/* design/v810_fetch.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_fetch import v810_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    output logic [`V810_XLEN-1:0] ia,
    input  logic [31:0]           id,
    v810_fetch_if.fetch           fetch_if
);

    logic [`V810_XLEN-1:0] pc;
    logic [`V810_XLEN-1:0] pc_step;
    logic [`V810_XLEN-1:0] fetch_addr;
    fetch_state_e          state;
    logic [31:0]           pd;
    logic [31:0]           ir;
    logic                  ins32;
    logic                  wrap;
    logic                  pc_inc;

    // Formats IV, V and VI are 32 bits long
    function automatic logic is_ins32(input logic [15:0] ins);
        casez (ins[15:10])
            6'b101???,
            6'b110?0?, 6'b110?11,
            6'b1110??, 6'b11110?,
            6'b111111: is_ins32 = 1'b1;
            default:   is_ins32 = 1'b0;
        endcase
    endfunction

    assign pc_step    = pc + (ins32 ? `V810_XLEN'(4) : `V810_XLEN'(2));
    assign fetch_addr = (state == FETCH_HI) ? pc_step : pc;
    assign ia         = {fetch_addr[`V810_XLEN-1:2], 2'b00}; // Word aligned

    //////////////////////////////////////////////////
    // Pre-decode

    always_comb begin
        if (state == FETCH_HI)
            pd = {id[15:0], fetch_if.ifid_ir[31:16]}; // Saved low half
        else if (pc[1])
            pd = {id[15:0], id[31:16]};
        else
            pd = id;
    end

    assign ins32  = is_ins32(pd[15:0]);
    assign wrap   = ins32 & pc[1];
    assign pc_inc = !(wrap && state == FETCH_LO); // Hold PC for second half

    always_comb begin
        ir = pd;
        if (!pc_inc)
            ir = {pd[15:0], 16'h0000};
    end

    //////////////////////////////////////////////////
    // PC and IF/ID register

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            state <= FETCH_LO;
        end else if (fetch_if.redirect) begin
            pc    <= fetch_if.redirect_pc;
            state <= FETCH_LO;
        end else if (!fetch_if.stall) begin
            if (pc_inc)
                pc <= pc_step;
            state <= (wrap && state == FETCH_LO) ? FETCH_HI : FETCH_LO;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            fetch_if.ifid_ir <= '0;
        else if (fetch_if.redirect)
            fetch_if.ifid_ir <= '0;           // Flush
        else if (!fetch_if.stall)
            fetch_if.ifid_ir <= ir;
    end

    always_ff @(posedge CLK) begin
        if (fetch_if.redirect || !fetch_if.stall)
            fetch_if.ifid_pc <= pc;
    end

endmodule

/* design/v810_decode.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_decode import v810_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    v810_fetch_if.decode          fetch_if,
    input  logic [`V810_RA_W-1:0] ex_wa,
    input  logic                  ex_we,
    input  logic                  ex_flag_wr,
    input  logic [`V810_RA_W-1:0] mem_wa,
    input  logic                  mem_we,
    input  logic                  wb_we,
    input  logic [`V810_RA_W-1:0] wb_wa,
    input  logic [`V810_XLEN-1:0] wb_wd,
    input  logic                  redirect_in,
    output idex_t                 idex
);

    logic [`V810_XLEN-1:0] rf [`V810_NREGS];
    logic [`V810_RA_W-1:0] ra1;
    logic [`V810_RA_W-1:0] ra2;
    logic [`V810_XLEN-1:0] rd1;
    logic [`V810_XLEN-1:0] rd2;
    logic [31:0]           ir;
    idex_t                 dec;
    idex_t                 idex_next;
    logic                  haz_data;
    logic                  haz_flag;
    logic                  stall;

    function automatic logic src_hit(
        input logic [`V810_RA_W-1:0] wa,
        input logic                  we,
        input logic [`V810_RA_W-1:0] a1,
        input logic [`V810_RA_W-1:0] a2
    );
        src_hit = we && (wa != '0) && (wa == a1 || wa == a2);
    endfunction

    assign ir = fetch_if.ifid_ir;

    //////////////////////////////////////////////////
    // Instruction decoder

    always_comb begin
        ra1 = '0;
        ra2 = '0;
        dec = '0;
        casez (ir[15:10])
            6'b0?0_00?, 6'b000_010, 6'b0?0_10?, 6'b0?0_111,
            6'b001_10?, 6'b001_110, 6'b001_111: begin   // ALU ops
                if (!(ir[13:10] == ALU_MOV || ir[14:10] == 5'b01111))
                    ra2 = ir[9:5];
                if (ir[14])
                    dec.src1 = SRC1_IMM5;
                else
                    ra1 = ir[4:0];
                dec.wa        = ir[9:5];
                dec.alu_op    = alu_op_e'(ir[13:10]);
                dec.reg_write = 1'b1;
            end
            6'b0?0_011: begin                           // CMP
                ra2 = ir[9:5];
                if (ir[14])
                    dec.src1 = SRC1_IMM5;
                else
                    ra1 = ir[4:0];
                dec.alu_op    = ALU_SUB;
                dec.flag_mask = 4'b1111;
            end
            6'b100_???: begin                           // Bcond
                dec.src1   = SRC1_PC;
                dec.src2   = SRC2_DISP9;
                dec.alu_op = ALU_ADD;
                dec.branch = 1'b1;
                dec.cond   = ir[12:9];
            end
            6'b110_0??: begin                           // LD
                ra1            = ir[4:0];
                dec.wa         = ir[9:5];
                dec.src2       = SRC2_DISP16;
                dec.alu_op     = ALU_ADD;
                dec.mem_read   = 1'b1;
                dec.mem_to_reg = 1'b1;
                dec.reg_write  = 1'b1;
            end
            6'b110_1??: begin                           // ST
                ra1           = ir[4:0];
                ra2           = ir[9:5];
                dec.src2      = SRC2_DISP16;
                dec.alu_op    = ALU_ADD;
                dec.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file, r0 reads as zero

    assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
    assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

    always_ff @(posedge CLK) begin
        if (wb_we)
            rf[wb_wa] <= wb_wd;
    end

    //////////////////////////////////////////////////
    // Hazards

    // No forwarding, wait until the writer has left WB
    assign haz_data = src_hit(ex_wa, ex_we, ra1, ra2)
                    | src_hit(mem_wa, mem_we, ra1, ra2)
                    | src_hit(wb_wa, wb_we, ra1, ra2);
    assign haz_flag = ex_flag_wr & dec.branch;   // PSW not yet updated
    assign stall    = haz_data | haz_flag;

    assign fetch_if.stall = stall;

    always_comb begin
        idex_next        = dec;
        idex_next.pc     = fetch_if.ifid_pc;
        idex_next.imm5   = `V810_XLEN'($signed(ir[4:0]));
        idex_next.disp9  = `V810_XLEN'($signed(ir[8:0]));
        idex_next.disp16 = `V810_XLEN'($signed(ir[31:16]));
        idex_next.rd1    = rd1;
        idex_next.rd2    = rd2;
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n)
            idex <= '0;
        else if (stall || redirect_in)
            idex <= '0;                    // Bubble
        else
            idex <= idex_next;
    end

endmodule

/* design/v810_execute.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_execute import v810_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  idex_t                 idex,
    input  flags_t                psw,
    v810_fetch_if.execute         fetch_if,
    output logic [`V810_RA_W-1:0] ex_wa,
    output logic                  ex_we,
    output logic                  ex_flag_wr,
    output exmem_t                exmem
);

    logic [`V810_XLEN-1:0] in1;
    logic [`V810_XLEN-1:0] in2;
    logic [`V810_XLEN-1:0] alu_out;
    flags_t                alu_fl;
    logic                  cond_match;

    always_comb begin
        case (idex.src1)
            SRC1_IMM5: in1 = idex.imm5;
            SRC1_PC:   in1 = idex.pc;
            default:   in1 = idex.rd1;
        endcase
        case (idex.src2)
            SRC2_DISP16: in2 = idex.disp16;
            SRC2_DISP9:  in2 = idex.disp9;
            default:     in2 = idex.rd2;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU, result is in2 op in1

    always_comb begin
        alu_fl  = '0;
        alu_out = in1;
        case (idex.alu_op)
            ALU_MOV: alu_out = in1;
            ALU_ADD: begin
                {alu_fl.carry, alu_out} = {1'b0, in2} + {1'b0, in1};
                alu_fl.over = (in1[`V810_XLEN-1] == in2[`V810_XLEN-1])
                            & (in2[`V810_XLEN-1] != alu_out[`V810_XLEN-1]);
            end
            ALU_SUB: begin
                {alu_fl.carry, alu_out} = {1'b0, in2} - {1'b0, in1}; // Borrow
                alu_fl.over = (in1[`V810_XLEN-1] != in2[`V810_XLEN-1])
                            & (in2[`V810_XLEN-1] != alu_out[`V810_XLEN-1]);
            end
            ALU_SHL: alu_out = in2 << in1[4:0];
            ALU_SHR: alu_out = in2 >> in1[4:0];
            ALU_SAR: alu_out = $signed(in2) >>> in1[4:0];
            ALU_OR:  alu_out = in1 | in2;
            ALU_AND: alu_out = in1 & in2;
            ALU_XOR: alu_out = in1 ^ in2;
            ALU_NOT: alu_out = ~in1;
            default: alu_out = in1;
        endcase
        alu_fl.zero = ~|alu_out;
        alu_fl.sign = alu_out[`V810_XLEN-1];
    end

    //////////////////////////////////////////////////
    // Branch condition

    always_comb begin
        case (idex.cond[2:0])
            3'b000: cond_match = psw.over;
            3'b001: cond_match = psw.carry;                          // Lower
            3'b010: cond_match = psw.zero;                           // Equal
            3'b011: cond_match = psw.carry | psw.zero;               // Not higher
            3'b100: cond_match = psw.sign;
            3'b101: cond_match = 1'b1;                               // Always
            3'b110: cond_match = psw.sign ^ psw.over;                // Less than
            default: cond_match = (psw.sign ^ psw.over) | psw.zero;
        endcase
        cond_match = cond_match ^ idex.cond[3];  // Upper bit inverts
    end

    assign fetch_if.redirect    = idex.branch & cond_match;
    assign fetch_if.redirect_pc = alu_out;       // pc + disp9

    // Hazard info back to decode
    assign ex_wa      = idex.wa;
    assign ex_we      = idex.reg_write;
    assign ex_flag_wr = |idex.flag_mask;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            exmem <= '0;
        end else begin
            exmem.result     <= alu_out;
            exmem.flags      <= alu_fl;
            exmem.st_data    <= idex.rd2;
            exmem.wa         <= idex.wa;
            exmem.mem_read   <= idex.mem_read;
            exmem.mem_write  <= idex.mem_write;
            exmem.flag_mask  <= idex.flag_mask;
            exmem.reg_write  <= idex.reg_write;
            exmem.mem_to_reg <= idex.mem_to_reg;
        end
    end

endmodule

/* design/v810_memory.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_memory import v810_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  exmem_t                exmem,
    output logic [`V810_XLEN-1:0] da,
    output logic [`V810_XLEN-1:0] dd_o,
    input  logic [`V810_XLEN-1:0] dd_i,
    output logic                  mrq_n,
    output logic                  rw,
    output flags_t                psw,
    output logic [`V810_RA_W-1:0] mem_wa,
    output logic                  mem_we,
    output logic                  wb_we,
    output logic [`V810_RA_W-1:0] wb_wa,
    output logic [`V810_XLEN-1:0] wb_wd
);

    logic                  memwb_we;
    logic                  memwb_m2r;
    logic [`V810_XLEN-1:0] memwb_result;
    logic [`V810_XLEN-1:0] memwb_load;

    // Data bus
    assign da    = exmem.result;
    assign dd_o  = exmem.st_data;
    assign mrq_n = ~(exmem.mem_read | exmem.mem_write);
    assign rw    = mrq_n | exmem.mem_read;  // Low only for a store

    assign mem_wa = exmem.wa;
    assign mem_we = exmem.reg_write;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            psw       <= '0;
            memwb_we  <= 1'b0;
            wb_wa     <= '0;
            memwb_m2r <= 1'b0;
        end else begin
            psw       <= flags_t'((psw & ~exmem.flag_mask) | (exmem.flags & exmem.flag_mask));
            memwb_we  <= exmem.reg_write;
            wb_wa     <= exmem.wa;
            memwb_m2r <= exmem.mem_to_reg;
        end
    end

    always_ff @(posedge CLK) begin
        memwb_result <= exmem.result;
        memwb_load   <= dd_i;           // Load data arrives this cycle
    end

    assign wb_we = memwb_we & |wb_wa;   // r0 stays zero
    assign wb_wd = memwb_m2r ? memwb_load : memwb_result;

endmodule

/* design/v810_core.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_core import v810_pkg::*; (
    input  logic                  CLK,
    input  logic                  arst_n,
    output logic [`V810_XLEN-1:0] ia,
    input  logic [31:0]           id,
    output logic [`V810_XLEN-1:0] da,
    input  logic [`V810_XLEN-1:0] dd_i,
    output logic [`V810_XLEN-1:0] dd_o,
    output logic                  mrq_n,
    output logic                  rw
);

    idex_t                 idex;
    exmem_t                exmem;
    flags_t                psw;
    logic [`V810_RA_W-1:0] ex_wa;
    logic                  ex_we;
    logic                  ex_flag_wr;
    logic [`V810_RA_W-1:0] mem_wa;
    logic                  mem_we;
    logic                  wb_we;
    logic [`V810_RA_W-1:0] wb_wa;
    logic [`V810_XLEN-1:0] wb_wd;

    v810_fetch_if fetch_bus ();

    v810_fetch u_fetch (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .ia       (ia),
        .id       (id),
        .fetch_if (fetch_bus)
    );

    v810_decode u_decode (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .fetch_if    (fetch_bus),
        .ex_wa       (ex_wa),
        .ex_we       (ex_we),
        .ex_flag_wr  (ex_flag_wr),
        .mem_wa      (mem_wa),
        .mem_we      (mem_we),
        .wb_we       (wb_we),
        .wb_wa       (wb_wa),
        .wb_wd       (wb_wd),
        .redirect_in (fetch_bus.redirect),   // Flush ID/EX on taken branch
        .idex        (idex)
    );

    v810_execute u_execute (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .idex       (idex),
        .psw        (psw),
        .fetch_if   (fetch_bus),
        .ex_wa      (ex_wa),
        .ex_we      (ex_we),
        .ex_flag_wr (ex_flag_wr),
        .exmem      (exmem)
    );

    v810_memory u_memory (
        .CLK    (CLK),
        .arst_n (arst_n),
        .exmem  (exmem),
        .da     (da),
        .dd_o   (dd_o),
        .dd_i   (dd_i),
        .mrq_n  (mrq_n),
        .rw     (rw),
        .psw    (psw),
        .mem_wa (mem_wa),
        .mem_we (mem_we),
        .wb_we  (wb_we),
        .wb_wa  (wb_wa),
        .wb_wd  (wb_wd)
    );

endmodule

/* verif/v810_checker.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_checker #(
    parameter logic [`V810_XLEN-1:0] ST_ADDR = 32'h0000_0100
) (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic [`V810_XLEN-1:0] da,
    input  logic [`V810_XLEN-1:0] dd_o,
    input  logic                  mrq_n,
    input  logic                  rw,
    input  logic [`V810_XLEN-1:0] exp_data,   // Expected store data for this row
    output int unsigned           stores,
    output int unsigned           errors
);

    int unsigned n_stores = 0;
    int unsigned n_errors = 0;
    logic        after_rst = 1'b0;           // Set from the second edge after reset

    //////////////////////////////////////////////////
    // Bus snooping

    always @(posedge CLK) begin
        if (!arst_n || !after_rst) begin
            // Bus must stay idle in and just after reset
            if (!mrq_n || !rw) begin
                n_errors <= n_errors + 1;
                $display("error at %0t ns: bus request active during or right after reset",
                         $time);
            end
        end else if (!mrq_n && !rw) begin
            n_stores <= n_stores + 1;
            if (da !== ST_ADDR || dd_o !== exp_data) begin
                n_errors <= n_errors + 1;
                $display("mismatch at %0t ns: store of %h to %h, expected %h to %h",
                         $time, dd_o, da, exp_data, ST_ADDR);
            end
        end
        after_rst <= arst_n;
    end

    assign stores = n_stores;
    assign errors = n_errors;

endmodule

/* verif/v810_tb.sv */
`timescale 1ns/1ps
`include "v810_defines.svh"

module v810_tb import v810_pkg::*; ();

    typedef enum logic [1:0] {
        M_REG,
        M_IMM,
        M_BR
    } mode_e;

    typedef struct packed {
        alu_op_e    op;
        mode_e      mode;
        logic [3:0] cond;   // Branch rows only, bit 3 inverts
        logic       pad;    // Leading 16-bit NOP, puts the LDs at offset 2
    } row_t;

    localparam int          NROWS       = 27;
    localparam int unsigned CYCLE_LIMIT = NROWS * 40;
    localparam logic [31:0] LFSR_SEED   = 32'h8aba546a;
    localparam logic [31:0] LFSR_TAPS   = 32'hA300_0000;
    localparam logic [5:0]  LD_W        = 6'b110011;
    localparam logic [5:0]  ST_W        = 6'b110111;
    localparam logic [3:0]  OP_CMP      = 4'b0011;
    localparam logic [3:0]  COND_ALWAYS = 4'b0101;
    localparam logic [15:0] ST_DISP     = 16'h0100;

    localparam row_t TESTS [NROWS] = '{
        '{ALU_MOV, M_REG, 4'h0, 1'b0}, '{ALU_ADD, M_REG, 4'h0, 1'b1},
        '{ALU_SUB, M_REG, 4'h0, 1'b0}, '{ALU_SHL, M_REG, 4'h0, 1'b1},
        '{ALU_SHR, M_REG, 4'h0, 1'b0}, '{ALU_SAR, M_REG, 4'h0, 1'b1},
        '{ALU_OR,  M_REG, 4'h0, 1'b0}, '{ALU_AND, M_REG, 4'h0, 1'b1},
        '{ALU_XOR, M_REG, 4'h0, 1'b0}, '{ALU_NOT, M_REG, 4'h0, 1'b1},
        '{ALU_MOV, M_IMM, 4'h0, 1'b1}, '{ALU_ADD, M_IMM, 4'h0, 1'b0},
        '{ALU_SHL, M_IMM, 4'h0, 1'b1}, '{ALU_SHR, M_IMM, 4'h0, 1'b0},
        '{ALU_SAR, M_IMM, 4'h0, 1'b1},
        '{ALU_SUB, M_BR,  4'h0, 1'b0}, '{ALU_SUB, M_BR,  4'h1, 1'b1},
        '{ALU_SUB, M_BR,  4'h2, 1'b0}, '{ALU_SUB, M_BR,  4'h3, 1'b1},
        '{ALU_SUB, M_BR,  4'h4, 1'b0}, '{ALU_SUB, M_BR,  4'h6, 1'b1},
        '{ALU_SUB, M_BR,  4'h7, 1'b0}, '{ALU_SUB, M_BR,  4'h9, 1'b1},
        '{ALU_SUB, M_BR,  4'hA, 1'b0}, '{ALU_SUB, M_BR,  4'hB, 1'b1},
        '{ALU_SUB, M_BR,  4'hE, 1'b0}, '{ALU_SUB, M_BR,  4'hF, 1'b1}
    };

    logic                  CLK;
    logic                  arst_n   = 1'b0;
    logic [`V810_XLEN-1:0] ia;
    logic [31:0]           id       = '0;
    logic [`V810_XLEN-1:0] da;
    logic [`V810_XLEN-1:0] dd_i     = '0;
    logic [`V810_XLEN-1:0] dd_o;
    logic                  mrq_n;
    logic                  rw;
    logic [`V810_XLEN-1:0] exp_data = '0;
    int unsigned           stores;
    int unsigned           errors;
    int unsigned           cycles    = 0;
    int unsigned           rows_done = 0;
    logic [31:0]           lfsr      = LFSR_SEED;
    logic [31:0]           imem [64];
    logic [31:0]           dmem [256];
    logic [6:0]            hp;                  // Halfword write pointer

    v810_core DUT (
        .CLK    (CLK),
        .arst_n (arst_n),
        .ia     (ia),
        .id     (id),
        .da     (da),
        .dd_i   (dd_i),
        .dd_o   (dd_o),
        .mrq_n  (mrq_n),
        .rw     (rw)
    );

    v810_checker u_checker (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .da       (da),
        .dd_o     (dd_o),
        .mrq_n    (mrq_n),
        .rw       (rw),
        .exp_data (exp_data),
        .stores   (stores),
        .errors   (errors)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) cycles <= cycles + 1;

    // Memory models, read data set up on the falling edge
    always @(negedge CLK) begin
        id   <= imem[ia[7:2]];
        dd_i <= dmem[da[9:2]];
    end

    //////////////////////////////////////////////////
    // Random operands and reference model

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Few distinct values so that equal, carry and overflow all show up
    function automatic logic [31:0] branch_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = draw_bits(2);
        lo = draw_bits(1);
        return {hi[1:0], 29'b0, lo[0]};
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] b,
                                            input logic [31:0] a);
        case (op)
            ALU_MOV: return a;
            ALU_ADD: return b + a;
            ALU_SUB: return b - a;
            ALU_SHL: return b << a[4:0];
            ALU_SHR: return b >> a[4:0];
            ALU_SAR: return $signed(b) >>> a[4:0];
            ALU_OR:  return b | a;
            ALU_AND: return b & a;
            ALU_XOR: return b ^ a;
            default: return ~a;
        endcase
    endfunction

    // Outcome of CMP a, b then Bcond
    function automatic logic branch_ref(input logic [3:0] cond, input logic [31:0] b,
                                        input logic [31:0] a);
        logic [31:0] diff;
        logic        lt;
        logic        taken;
        diff = b - a;
        lt   = $signed(b) < $signed(a);
        case (cond[2:0])
            3'd0:    taken = lt ^ diff[31];   // Signed overflow
            3'd1:    taken = b < a;
            3'd2:    taken = b == a;
            3'd3:    taken = b <= a;
            3'd4:    taken = diff[31];
            3'd5:    taken = 1'b1;
            3'd6:    taken = lt;
            default: taken = lt | (b == a);
        endcase
        return taken ^ cond[3];
    endfunction

    //////////////////////////////////////////////////
    // Program assembly

    function automatic logic [15:0] enc_alu(input logic imm, input logic [3:0] op,
                                            input logic [4:0] r2, input logic [4:0] r1);
        return {1'b0, imm, op, r2, r1};
    endfunction

    function automatic logic [15:0] enc_mem(input logic [5:0] opc, input logic [4:0] r2,
                                            input logic [4:0] r1);
        return {opc, r2, r1};
    endfunction

    function automatic logic [15:0] enc_bcond(input logic [3:0] cond, input logic [8:0] disp);
        return {3'b100, cond, disp};
    endfunction

    task automatic put16(input logic [15:0] h);
        if (hp[0])
            imem[hp[6:1]][31:16] = h;
        else
            imem[hp[6:1]][15:0] = h;
        hp = hp + 7'd1;
    endtask

    task automatic put32(input logic [15:0] h, input logic [15:0] disp);
        put16(h);
        put16(disp);
    endtask

    task automatic run_row(input row_t t);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] expv;
        int unsigned prev;
        arst_n = 1'b0;
        imem   = '{default: '0};
        hp     = '0;
        a      = (t.mode == M_BR) ? branch_operand() : draw_bits(32);
        b      = (t.mode == M_BR) ? branch_operand() : draw_bits(32);
        imm    = draw_bits(5);
        imm    = {{27{imm[4]}}, imm[4:0]};
        if (t.pad)
            put16(16'h0000);
        if (t.mode == M_BR) begin
            put16(enc_alu(1'b1, ALU_MOV, 5'd4, 5'd1));
            put16(enc_alu(1'b1, ALU_MOV, 5'd5, 5'd2));
        end
        put32(enc_mem(LD_W, 5'd2, 5'd0), 16'h0200);   // r2 = a
        put32(enc_mem(LD_W, 5'd3, 5'd0), 16'h0204);   // r3 = b, used right away
        case (t.mode)
            M_REG: begin
                put16(enc_alu(1'b0, t.op, 5'd3, 5'd2));
                put32(enc_mem(ST_W, 5'd3, 5'd0), ST_DISP);
                expv = alu_ref(t.op, b, a);
            end
            M_IMM: begin
                put16(enc_alu(1'b1, t.op, 5'd3, imm[4:0]));
                put32(enc_mem(ST_W, 5'd3, 5'd0), ST_DISP);
                expv = alu_ref(t.op, b, imm);
            end
            default: begin
                put16(enc_alu(1'b0, OP_CMP, 5'd3, 5'd2));
                put16(enc_bcond(t.cond, 9'd8));          // Over ST 1 and BR
                put32(enc_mem(ST_W, 5'd4, 5'd0), ST_DISP);
                put16(enc_bcond(COND_ALWAYS, 9'd6));     // Over ST 2
                put32(enc_mem(ST_W, 5'd5, 5'd0), ST_DISP);
                expv = branch_ref(t.cond, b, a) ? 32'd2 : 32'd1;
            end
        endcase
        put16(enc_bcond(COND_ALWAYS, 9'd0));             // Spin here
        dmem[128] = a;
        dmem[129] = b;
        exp_data  = expv;
        repeat (2) @(negedge CLK);
        prev   = stores;
        arst_n = 1'b1;
        wait (stores != prev);
        @(negedge CLK);
        rows_done++;
    endtask

    //////////////////////////////////////////////////
    // Run control

    task automatic close_run(input logic timed_out);
        $display("rows %0d of %0d, stores %0d, errors %0d",
                 rows_done, NROWS, stores, errors + timed_out);
        if (errors == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    initial begin
        for (int i = 0; i < 256; i++)
            dmem[i[7:0]] = 32'(i) * 32'h9e37_79b9;
        @(negedge CLK);
        for (int r = 0; r < NROWS; r++)
            run_row(TESTS[r[4:0]]);
        close_run(1'b0);
    end

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout: row %0d produced no store within %0d cycles", rows_done, cycles);
        close_run(1'b1);
    end

endmodule

/* flist.f */
+incdir+include
design/v810_pkg.sv
design/v810_fetch_if.sv
design/v810_fetch.sv
design/v810_decode.sv
design/v810_execute.sv
design/v810_memory.sv
design/v810_core.sv
verif/v810_checker.sv
verif/v810_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= v810_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
